// File: Makefile
# Verilator build and run for the MMIX instruction decoder testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = decoder_tb
FILELIST  = src.f
OBJ_DIR   = obj_dir
LOG       = sim.log
SIM_OPTS  = +verilator+error+limit+1000

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(SIM_OPTS) 2>&1 | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "STATUS: PASS" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: src.f
+incdir+verilog
verilog/mmix_pkg.sv
verilog/lookup_stage.sv
verilog/operand_stage.sv
verilog/inst_decoder.sv
test/decoder_chk.sv
test/decoder_tb.sv

// File: test/decoder_chk.sv
// decoder output checks: reset, hold under back-pressure and two-cycle latency
`timescale 1ns/1ns

module decoder_chk import mmix_pkg::*; (
	input logic     clk,
	input logic     rst_n,
	input logic     in_valid,
	input logic     in_ready,
	input logic     out_valid,
	input logic     out_ready,
	input decoded_t out_dec
);

	int unsigned fail_count = 0;   // read by the testbench at the end

	// a reset edge leaves the output slot empty
	reset_empty: assert property (@(posedge clk) !rst_n |=> !out_valid)
		else begin
			fail_count++;
			$error("out_valid high after a reset edge");
		end

	// stalled output keeps its item
	hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_dec))
		else begin
			fail_count++;
			$error("output changed or dropped while out_ready was low");
		end

	// accept, then stage 2 free on the next edge, gives out_valid one edge later
	two_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		out_ready && $past(in_valid && in_ready) |=> out_valid)
		else begin
			fail_count++;
			$error("out_valid missing two cycles after an accept");
		end

endmodule

bind inst_decoder decoder_chk u_chk (.*);

// File: test/decoder_tb.sv
// testbench for the MMIX decoder: random fetches checked against a reference decode
`timescale 1ns/1ns

module decoder_tb import mmix_pkg::*;;

	logic     clk = 1'b0;
	logic     rst_n;
	logic     in_valid;
	logic     in_ready;
	fetch_t   in_fetch;
	logic     out_valid;
	logic     out_ready;
	decoded_t out_dec;

	logic        bp_on;                 // random out_ready when set
	logic [63:0] rng = 64'd27;          // stimulus stream
	logic [63:0] bp_rng = 64'd27;       // back-pressure stream
	decoded_t    expected_q[$];
	int          errors = 0;
	int          timeouts = 0;
	int          sent = 0;
	int          received = 0;

	localparam internal_op_t arith_ops [4] = '{add, addu, sub, subu};
	localparam internal_op_t shift_ops [4] = '{shl, shlu, shr, shru};
	localparam internal_op_t logic_ops [8] = '{or_op, orn, nor_op, xor_op,
		and_op, andn, nand_op, nxor};
	localparam internal_op_t wyde_ops  [4] = '{set, addu, or_op, andn};  // SET, INC, OR, ANDN

	inst_decoder UUT (.*);

	initial forever #5 clk = ~clk;

	function automatic logic [63:0] xorshift64(input logic [63:0] s);
		logic [63:0] v;
		v = s ^ (s << 13);
		v = v ^ (v >> 7);
		v = v ^ (v << 17);
		return v;
	endfunction

	// operand source, register kind means look at g and the ring
	function automatic spec_t source_spec(input src_kind_t k, input logic [7:0] r, input ctx_t c);
		spec_t      s;
		logic [7:0] slot;
		s    = '0;
		slot = c.o[7:0] + r;   // 256-entry ring wraps by itself
		if (k == src_imm) begin
			s.kind  = src_imm;
			s.value = {56'h0, r};
		end else if (k != src_none) begin
			s.kind = (r >= c.g) ? src_global : src_local;
			s.idx  = (r >= c.g) ? r : slot;
		end
		return s;
	endfunction

	function automatic decoded_t ref_decode(input fetch_t f);
		decoded_t    d;
		logic [7:0]  op, x, y, z;
		src_kind_t   yk, zk;
		logic        xsrc, xdst, rel, wyde;
		logic [63:0] disp;
		spec_t       xs;
		{op, x, y, z} = f.inst;
		d     = '0;
		d.loc = f.loc;
		d.op  = op;
		yk    = src_global;                        // ALU shape unless changed below
		zk    = op[0] ? src_imm : src_global;
		xsrc  = 1'b0;
		xdst  = 1'b1;
		rel   = 1'b0;
		wyde  = 1'b0;
		case (op) inside
			[8'h20:8'h27]: d.iop = arith_ops[op[2:1]];
			[8'h30:8'h33]: d.iop = op[1] ? cmpu : cmp;
			[8'h34:8'h37]: begin
				d.iop = op[1] ? subu : sub;          // NEG
				yk    = src_imm;
			end
			[8'h38:8'h3F]: d.iop = shift_ops[op[2:1]];
			[8'h40:8'h5F]: begin
				d.iop = op[4] ? pbr : br;
				rel   = 1'b1;
				xsrc  = 1'b1;
				xdst  = 1'b0;
			end
			[8'h60:8'h6F]: begin
				d.iop = cset;
				xsrc  = 1'b1;
			end
			[8'h80:8'h8F]: d.iop = ld;
			[8'hA0:8'hAF]: begin
				d.iop = st;
				xsrc  = 1'b1;
				xdst  = 1'b0;
			end
			[8'hC0:8'hCF]: d.iop = logic_ops[op[3:1]];
			[8'hE0:8'hEF]: begin
				d.iop = wyde_ops[op[3:2]];
				yk    = src_none;
				wyde  = 1'b1;
				xsrc  = (op[3:2] != 2'd0);           // SETx does not read $X
			end
			8'hF0, 8'hF1: begin
				d.iop = jmp;
				rel   = 1'b1;
				xdst  = 1'b0;
			end
			8'hF4, 8'hF5: begin
				d.iop = set;                         // GETA
				rel   = 1'b1;
			end
			8'hFF: begin
				d.iop = f.loc[63] ? noop : trip;
				yk    = f.loc[63] ? src_none : src_global;
				zk    = f.loc[63] ? src_none : src_global;
				xdst  = 1'b0;
			end
			default: begin
				d.iop   = trap;                      // TRAP itself or unsupported
				d.fault = (op != 8'h00);
				zk      = src_global;
				xdst    = 1'b0;
			end
		endcase

		if (rel) begin
			if (op[7:1] == 7'h78)
				disp = {40'h0, x, y, z} - (op[0] ? 64'h100_0000 : 64'h0);
			else
				disp = {48'h0, y, z} - (op[0] ? 64'h1_0000 : 64'h0);
			d.y = '{src_imm, f.loc + 64'd4, 8'h0};
			d.z = '{src_imm, f.loc + disp * 4, 8'h0};
		end else begin
			d.y = source_spec(yk, y, f.ctx);
			if (wyde)
				d.z = '{src_imm, {48'h0, y, z} << (16 * (3 - op[1:0])), 8'h0};
			else
				d.z = source_spec(zk, z, f.ctx);
		end

		xs = source_spec(src_global, x, f.ctx);
		if (xsrc)
			d.b = xs;
		if (xdst && x >= f.ctx.l && x < f.ctx.g) begin
			d.iop   = trap;                          // marginal X
			d.fault = 1'b1;
		end else if (xdst) begin
			d.x = '{1'b1, xs.kind, xs.idx};
		end
		return d;
	endfunction

	// small X values are frequent so local and marginal X come up often
	task automatic random_fetch(input logic [7:0] op, input logic neg, output fetch_t f);
		logic [63:0] r1, r2;
		rng  = xorshift64(rng);
		r1   = rng;
		rng  = xorshift64(rng);
		r2   = rng;
		f.inst  = {op, r1[7:0] & (r1[8] ? 8'hFF : 8'h1F), r1[23:16], r1[31:24]};
		f.ctx.g = 8'd32 + 8'(r1[47:40] % 224);
		f.ctx.l = 8'(r1[63:56] % (f.ctx.g + 1));
		f.ctx.o = r2[61:0];
		f.loc   = {neg, r2[62:0] ^ {r1[31:0], 31'h0}};
	endtask

	task automatic send(input fetch_t f);
		int   waited;
		logic accepted;
		waited   = 0;
		accepted = 1'b0;
		in_valid <= 1'b1;
		in_fetch <= f;
		while (!accepted && waited < 50) begin
			@(posedge clk);
			accepted = in_ready;       // pre-edge value, the one the DUT saw
			waited++;
		end
		assert (accepted) else begin
			timeouts++;
			$display("timeout at %0t: decoder did not accept an instruction", $time);
		end
		if (accepted)
			sent++;
	endtask

	task automatic check_field(input string name, input logic [79:0] got,
		input logic [79:0] want);
		assert (got === want) else begin
			errors++;
			$display("Fail %0t %s got %h expected %h", $time, name, got, want);
		end
	endtask

	always @(posedge clk) begin
		bp_rng = xorshift64(bp_rng);
		out_ready <= bp_on ? bp_rng[40] : 1'b1;
	end

	// expected record for every accepted fetch
	always @(posedge clk) begin
		if (rst_n && in_valid && in_ready)
			expected_q.push_back(ref_decode(in_fetch));
	end

	always @(posedge clk) begin : compare
		decoded_t want;
		if (rst_n && out_valid && out_ready) begin
			received++;
			assert (expected_q.size() > 0) else begin
				errors++;
				$display("output at %0t with no instruction pending", $time);
			end
			if (expected_q.size() > 0) begin
				want = expected_q.pop_front();
				check_field("out_dec.loc", out_dec.loc, want.loc);
				check_field("out_dec.op", out_dec.op, want.op);
				check_field("out_dec.iop", out_dec.iop, want.iop);
				check_field("out_dec.x", out_dec.x, want.x);
				check_field("out_dec.y", out_dec.y, want.y);
				check_field("out_dec.z", out_dec.z, want.z);
				check_field("out_dec.b", out_dec.b, want.b);
				check_field("out_dec.fault", out_dec.fault, want.fault);
			end
		end
	end

	initial begin
		fetch_t f;
		int     waited;
		rst_n     = 1'b0;
		in_valid  = 1'b0;
		in_fetch  = '0;
		out_ready = 1'b0;
		bp_on     = 1'b0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;

		// every opcode at a positive then a negative location, out_ready high
		for (int pass = 0; pass < 2; pass++) begin
			for (int op = 0; op < 256; op++) begin
				random_fetch(8'(op), pass[0], f);
				send(f);
			end
		end

		bp_on <= 1'b1;
		for (int n = 0; n < 400; n++) begin
			rng = xorshift64(rng);
			random_fetch(rng[15:8], rng[63], f);
			send(f);
		end
		in_valid <= 1'b0;
		bp_on    <= 1'b0;

		waited = 0;
		while (received < sent && waited < 200) begin
			@(posedge clk);
			waited++;
		end
		assert (received == sent) else begin
			timeouts++;
			$display("timeout: %0d instructions sent but only %0d came out", sent, received);
		end
		repeat (2) @(posedge clk);

		$display("errors: %0d compare, %0d timeout, %0d assertion (%0d instructions)",
			errors, timeouts, UUT.u_chk.fail_count, sent);
		if (errors == 0 && timeouts == 0 && UUT.u_chk.fail_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// File: verilog/inst_decoder.sv
// MMIX two-stage pipelined instruction decoder: table lookup then operand specs
`timescale 1ns/1ns
`include "mmix_cfg.svh"

module inst_decoder import mmix_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     in_valid,
	output logic     in_ready,
	input  fetch_t   in_fetch,
	output logic     out_valid,
	input  logic     out_ready,
	output decoded_t out_dec
);

	// link between the stages
	logic    lk_valid;
	logic    lk_ready;
	lookup_t lk;

	// stage 1, opcode tables
	lookup_stage u_lookup (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.in_fetch (in_fetch),
		.lk_valid (lk_valid),
		.lk_ready (lk_ready),
		.lk       (lk)
	);

	// stage 2, register mapping and decoded record
	operand_stage u_operand (
		.clk       (clk),
		.rst_n     (rst_n),
		.lk_valid  (lk_valid),
		.lk_ready  (lk_ready),
		.lk        (lk),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_dec   (out_dec)
	);

endmodule

// File: verilog/lookup_stage.sv
// MMIX decode stage 1: holds the fetched instruction and looks up its op class and flags
`timescale 1ns/1ns
`include "mmix_cfg.svh"

module lookup_stage import mmix_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    in_valid,
	output logic    in_ready,
	input  fetch_t  in_fetch,
	output logic    lk_valid,
	input  logic    lk_ready,
	output lookup_t lk
);

	// TRAP flags, also used for every unsupported opcode
	localparam logic [7:0] trap_flags = `F_CTL | `F_Y_REG | `F_Z_REG;

	fetch_t       slot;          // single register slot
	logic [7:0]   op;
	logic [7:0]   alu_z;         // Z kind picked by the I bit
	logic [7:0]   alu_flags;
	internal_op_t iop;
	logic [7:0]   flags;
	logic         unsupported;

	// slot takes a new item when empty or draining this cycle
	assign in_ready = ~lk_valid | lk_ready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			lk_valid <= 1'b0;
		end else if (in_ready) begin
			lk_valid <= in_valid;   // empty slot when nothing comes in
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			slot <= in_fetch;
		end
	end

	assign op        = slot.inst[31:24];
	assign alu_z     = op[0] ? `F_Z_IMM : `F_Z_REG;  // odd opcode is the immediate form
	assign alu_flags = `F_X_DEST | `F_Y_REG | alu_z;

	// opcode table, decoded by ranges
	always_comb begin
		iop         = trap;
		flags       = trap_flags;
		unsupported = 1'b0;
		case (op) inside
			8'h00: begin
				iop   = trap;
				flags = trap_flags;
			end
			[8'h20:8'h27]: begin
				case (op[2:1])            // ADD, ADDU, SUB, SUBU pairs
					2'd0: iop = add;
					2'd1: iop = addu;
					2'd2: iop = sub;
					default: iop = subu;
				endcase
				flags = alu_flags;
			end
			[8'h30:8'h33]: begin
				iop   = op[1] ? cmpu : cmp;
				flags = alu_flags;
			end
			[8'h34:8'h37]: begin
				iop   = op[1] ? subu : sub;  // NEG is 0 - Z with Y as the immediate
				flags = `F_X_DEST | `F_Y_IMM | alu_z;
			end
			[8'h38:8'h3F]: begin
				case (op[2:1])
					2'd0: iop = shl;
					2'd1: iop = shlu;
					2'd2: iop = shr;
					default: iop = shru;
				endcase
				flags = alu_flags;
			end
			[8'h40:8'h4F]: begin
				iop   = br;
				flags = `F_X_SRC | `F_REL;   // test $X, target from YZ
			end
			[8'h50:8'h5F]: begin
				iop   = pbr;
				flags = `F_X_SRC | `F_REL;
			end
			[8'h60:8'h6F]: begin
				iop   = cset;
				flags = `F_X_SRC | `F_X_DEST | `F_Y_REG | alu_z;  // $X kept when test fails
			end
			[8'h80:8'h8F]: begin
				iop   = ld;
				flags = alu_flags;
			end
			[8'hA0:8'hAF]: begin
				iop   = st;
				flags = `F_X_SRC | `F_Y_REG | alu_z;  // $X is the store data
			end
			[8'hC0:8'hCF]: begin
				case (op[3:1])
					3'd0: iop = or_op;
					3'd1: iop = orn;
					3'd2: iop = nor_op;
					3'd3: iop = xor_op;
					3'd4: iop = and_op;
					3'd5: iop = andn;
					3'd6: iop = nand_op;
					default: iop = nxor;
				endcase
				flags = alu_flags;
			end
			[8'hE0:8'hE3]: begin
				iop   = set;                 // SETH..SETL
				flags = `F_X_DEST;
			end
			[8'hE4:8'hE7]: begin
				iop   = addu;                // INCH..INCL
				flags = `F_X_SRC | `F_X_DEST;
			end
			[8'hE8:8'hEB]: begin
				iop   = or_op;               // ORH..ORL
				flags = `F_X_SRC | `F_X_DEST;
			end
			[8'hEC:8'hEF]: begin
				iop   = andn;                // ANDNH..ANDNL
				flags = `F_X_SRC | `F_X_DEST;
			end
			[8'hF0:8'hF1]: begin
				iop   = jmp;
				flags = `F_REL | `F_CTL;
			end
			[8'hF4:8'hF5]: begin
				iop   = set;                 // GETA loads the address into $X
				flags = `F_X_DEST | `F_REL;
			end
			`OP_TRIP: begin
				if (slot.loc[63]) begin      // negative location turns TRIP into a no-op
					iop   = noop;
					flags = 8'h00;
				end else begin
					iop   = trip;
					flags = trap_flags;
				end
			end
			default: begin
				iop         = trap;          // everything else traps
				flags       = trap_flags;
				unsupported = 1'b1;
			end
		endcase
	end

	assign lk = '{fetch: slot, iop: iop, flags: flags, unsupported: unsupported};

endmodule

// File: verilog/mmix_cfg.svh
// MMIX decoder constants: widths, local ring mask, operand flag bits and opcode bases
`ifndef MMIX_CFG_SVH
`define MMIX_CFG_SVH

// datapath widths
`define WORD_W        64    // octabyte data and address
`define INST_W        32    // tetrabyte instruction
`define REG_W         8     // register number X, Y, Z
`define RING_W        62    // O/S offsets into the register stack

// local registers live in a 256-entry ring
`define LRING_MASK    255

// operand flag byte, one bit per property of the opcode
`define F_Z_IMM       8'h01 // Z is an immediate byte
`define F_Z_REG       8'h02 // $Z is a source
`define F_Y_IMM       8'h04 // Y is an immediate byte
`define F_Y_REG       8'h08 // $Y is a source
`define F_X_SRC       8'h10 // $X is a source (third operand B)
`define F_X_DEST      8'h20 // $X gets written
`define F_REL         8'h40 // YZ or XYZ is a relative address
`define F_CTL         8'h80 // control changes here

// opcodes the decoder tests directly
`define OP_JMP        8'hF0 // JMP, JMPB is 8'hF1
`define OP_TRIP       8'hFF
`define OP_WYDE_BASE  8'hE0 // SETH..ANDNL occupy 8'hE0-8'hEF

`endif

// File: verilog/mmix_pkg.sv
// MMIX decoder types: internal op classes, operand specs and the records passed between stages
`include "mmix_cfg.svh"

package mmix_pkg;

	// internal operation class, one byte wide
	typedef enum logic [7:0] {
		trap,
		noop,       // TRIP from a negative location
		add,
		addu,
		sub,
		subu,
		cmp,
		cmpu,
		shl,
		shlu,
		shr,
		shru,
		br,
		pbr,        // probable branch
		cset,
		ld,
		st,
		or_op,
		orn,
		nor_op,
		xor_op,
		and_op,
		andn,
		nand_op,
		nxor,
		set,        // SETH..SETL and GETA
		jmp,
		trip
	} internal_op_t;

	// where an operand comes from
	typedef enum logic [1:0] {
		src_none   = 2'd0,
		src_imm    = 2'd1,  // value field holds it
		src_global = 2'd2,  // idx is a global register number
		src_local  = 2'd3   // idx is a slot in the local ring
	} src_kind_t;

	typedef struct packed {
		src_kind_t             kind;
		logic [`WORD_W-1:0]    value;  // immediate or computed address
		logic [`REG_W-1:0]     idx;
	} spec_t;

	// X destination
	typedef struct packed {
		logic                  valid;
		src_kind_t             kind;
		logic [`REG_W-1:0]     idx;
	} dest_t;

	// register stack context as seen by one instruction
	typedef struct packed {
		logic [`REG_W-1:0]     g;
		logic [`REG_W-1:0]     l;
		logic [`RING_W-1:0]    o;
	} ctx_t;

	typedef struct packed {
		logic [`INST_W-1:0]    inst;
		logic [`WORD_W-1:0]    loc;
		ctx_t                  ctx;
	} fetch_t;

	// stage 1 result
	typedef struct packed {
		fetch_t                fetch;
		internal_op_t          iop;
		logic [7:0]            flags;
		logic                  unsupported;
	} lookup_t;

	// decoded record leaving the pipe
	typedef struct packed {
		logic [`WORD_W-1:0]    loc;
		logic [7:0]            op;
		internal_op_t          iop;
		dest_t                 x;
		spec_t                 y;
		spec_t                 z;
		spec_t                 b;
		logic                  fault;  // unsupported or marginal X
	} decoded_t;

endpackage

// File: verilog/operand_stage.sv
// MMIX decode stage 2: operand and destination specs from flags and stack context, output slot
`timescale 1ns/1ns
`include "mmix_cfg.svh"

module operand_stage import mmix_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     lk_valid,
	output logic     lk_ready,
	input  lookup_t  lk,
	output logic     out_valid,
	input  logic     out_ready,
	output decoded_t out_dec
);

	localparam logic [`RING_W-1:0] ring_mask = `LRING_MASK;

	logic [7:0]          op, xx, yy, zz;
	logic [15:0]         yz;
	logic [`WORD_W-1:0]  loc;
	ctx_t                ctx;
	logic [7:0]          f;
	logic [`WORD_W-1:0]  rel_off;   // 4 x signed offset
	logic [`WORD_W-1:0]  wyde;      // YZ moved to its wyde position
	spec_t               x_map;
	logic                marginal;
	decoded_t            nxt;

	// global when r >= G, otherwise a slot in the local ring at O + r
	function automatic spec_t map_reg(input logic [`REG_W-1:0] r, input ctx_t c);
		logic [`RING_W-1:0] ring;
		spec_t s;
		ring    = (c.o + {{(`RING_W-`REG_W){1'b0}}, r}) & ring_mask;
		s.value = '0;
		if (r >= c.g) begin
			s.kind = src_global;
			s.idx  = r;
		end else begin
			s.kind = src_local;
			s.idx  = ring[`REG_W-1:0];
		end
		return s;
	endfunction

	assign {op, xx, yy, zz} = lk.fetch.inst;
	assign yz  = {yy, zz};
	assign loc = lk.fetch.loc;
	assign ctx = lk.fetch.ctx;
	assign f   = lk.flags;

	// branch and GETA offsets are YZ, JMP uses XYZ; odd opcode means backward
	assign rel_off = ((op & 8'hFE) == `OP_JMP) ?
		{{(`WORD_W-26){op[0]}}, xx, yy, zz, 2'b00} :
		{{(`WORD_W-18){op[0]}}, yz, 2'b00};

	always_comb begin
		case (op[1:0])
			2'd0: wyde = {yz, 48'h0};       // high wyde
			2'd1: wyde = {16'h0, yz, 32'h0};
			2'd2: wyde = {32'h0, yz, 16'h0};
			default: wyde = {48'h0, yz};    // low wyde
		endcase
	end

	assign x_map    = map_reg(xx, ctx);
	// X between L and G would need the stack to grow
	assign marginal = |(f & `F_X_DEST) && (xx >= ctx.l) && (xx < ctx.g);

	always_comb begin
		nxt.loc   = loc;
		nxt.op    = op;
		nxt.iop   = marginal ? trap : lk.iop;
		nxt.fault = lk.unsupported | marginal;
		nxt.y     = '{kind: src_none, value: '0, idx: '0};
		nxt.z     = '{kind: src_none, value: '0, idx: '0};
		nxt.b     = '{kind: src_none, value: '0, idx: '0};
		nxt.x     = '{valid: 1'b0, kind: src_none, idx: '0};

		if (|(f & `F_REL)) begin
			nxt.y = '{kind: src_imm, value: loc + 64'd4, idx: '0};   // return address
			nxt.z = '{kind: src_imm, value: loc + rel_off, idx: '0}; // target
		end else begin
			if (op[7:4] == `OP_WYDE_BASE >> 4) begin
				nxt.z = '{kind: src_imm, value: wyde, idx: '0};
			end else if (|(f & `F_Z_IMM)) begin
				nxt.z = '{kind: src_imm, value: {56'h0, zz}, idx: '0};
			end else if (|(f & `F_Z_REG)) begin
				nxt.z = map_reg(zz, ctx);
			end
			if (|(f & `F_Y_IMM)) begin
				nxt.y = '{kind: src_imm, value: {56'h0, yy}, idx: '0};
			end else if (|(f & `F_Y_REG)) begin
				nxt.y = map_reg(yy, ctx);
			end
		end

		if (|(f & `F_X_SRC))
			nxt.b = x_map;      // $X read as third operand

		// destination only when X is plainly global or local
		if (|(f & `F_X_DEST) && !marginal) begin
			nxt.x = '{valid: 1'b1, kind: x_map.kind, idx: x_map.idx};
		end
	end

	// output slot, same accept rule as stage 1
	assign lk_ready = ~out_valid | out_ready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else if (lk_ready) begin
			out_valid <= lk_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (lk_valid && lk_ready)
			out_dec <= nxt;
	end

endmodule
